/* rtl/riscv_isa_pkg.sv */
package riscv_isa_pkg;

   // major opcodes, insn[6:0]
   typedef enum logic [6:0] {
      OPC_LOAD     = 7'h03,
      OPC_MISC_MEM = 7'h0f,
      OPC_OP_IMM   = 7'h13,
      OPC_AUIPC    = 7'h17,
      OPC_STORE    = 7'h23,
      OPC_OP       = 7'h33,
      OPC_LUI      = 7'h37,
      OPC_BRANCH   = 7'h63,
      OPC_JALR     = 7'h67,
      OPC_JAL      = 7'h6f,
      OPC_SYSTEM   = 7'h73
   } opcode_t;

   // supervisor and machine CSRs plus the read-only counters
   typedef enum logic [4:0] {
      SSTATUS,
      SIE,
      STVEC,
      SCOUNTEREN,
      SSCRATCH,
      SEPC,
      SCAUSE,
      STVAL,
      SIP,
      SATP,
      MSTATUS,
      MISA,
      MEDELEG,
      MIDELEG,
      MIE,
      MTVEC,
      MCOUNTEREN,
      MSCRATCH,
      MEPC,
      MCAUSE,
      MTVAL,
      MIP,
      PMPCFG0,
      PMPADDR0,
      PMPADDR1,
      PMPADDR2,
      PMPADDR3,
      RDCYCLE_CSR,
      RDTIME_CSR,
      RDINSTRET_CSR,
      MHARTID,
      BADCSR              // any unmapped address
   } csr_t;

   typedef enum logic [2:0] {
      IMM_NONE,
      IMM_I,
      IMM_S,
      IMM_B,              // pc relative
      IMM_U,
      IMM_J,              // pc relative
      IMM_CSR             // zero-extended rs1 field
   } imm_fmt_t;

endpackage

/* rtl/uop_pkg.sv */
package uop_pkg;

   typedef enum logic [5:0] {
      // loads
      LB,
      LH,
      LW,
      LD,
      LBU,
      LHU,
      LWU,
      // stores
      SB,
      SH,
      SW,
      SD,
      // register-immediate alu
      ADDI,
      SLLI,
      SLTI,
      SLTIU,
      XORI,
      SRLI,
      SRAI,
      ORI,
      ANDI,
      // register-register alu
      ADDU, SUBU, SLL, SLT, SLTU,
      XOR, SRL, SRA, OR, AND,
      LUI,
      AUIPC,
      BEQ, BNE, BLT, BGE, BLTU, BGEU,
      J,
      JAL,
      JR,
      JALR,
      RET,                // jr through x1 or x5
      CSRRW, CSRRS, CSRRC,
      CSRRWI, CSRRSI, CSRRCI,
      ECALL,
      EBREAK,
      NOP,
      II,                 // illegal instruction
      FETCH_PF
   } op_t;

endpackage

/* rtl/uop_if.sv */
`timescale 1ns/1ps

interface uop_if #(
   parameter int XLEN   = 64,
   parameter int PREG_W = 6
);
   import riscv_isa_pkg::*;
   import uop_pkg::*;

   op_t               op;
   logic [PREG_W-1:0] dst;
   logic              dst_valid;
   logic [PREG_W-1:0] src_a;
   logic              src_a_valid;
   logic [PREG_W-1:0] src_b;
   logic              src_b_valid;
   logic              is_br;
   logic              is_mem;
   logic              is_store;
   logic              serializing;
   csr_t              csr;
   logic [XLEN-1:0]   imm;

   modport classify (output op, dst, dst_valid, src_a, src_a_valid, src_b, src_b_valid,
                     is_br, is_mem, is_store, serializing, csr);
   modport imm_drv (output imm);
   modport sink (input op, dst, dst_valid, src_a, src_a_valid, src_b, src_b_valid,
                 is_br, is_mem, is_store, serializing, csr, imm);

endinterface

/* rtl/csr_map.sv */
`timescale 1ns/1ps

module csr_map (
   input  logic [11:0]         addr,
   output riscv_isa_pkg::csr_t csr
);
   import riscv_isa_pkg::*;

   always_comb
   begin
      case (addr)
         12'h100: csr = SSTATUS;
         12'h104: csr = SIE;
         12'h105: csr = STVEC;
         12'h106: csr = SCOUNTEREN;
         12'h140: csr = SSCRATCH;
         12'h141: csr = SEPC;
         12'h142: csr = SCAUSE;
         12'h143: csr = STVAL;
         12'h144: csr = SIP;
         12'h180: csr = SATP;
         12'h300: csr = MSTATUS;
         12'h301: csr = MISA;
         12'h302: csr = MEDELEG;
         12'h303: csr = MIDELEG;
         12'h304: csr = MIE;
         12'h305: csr = MTVEC;
         12'h306: csr = MCOUNTEREN;
         12'h340: csr = MSCRATCH;
         12'h341: csr = MEPC;
         12'h342: csr = MCAUSE;
         12'h343: csr = MTVAL;
         12'h344: csr = MIP;
         12'h3a0: csr = PMPCFG0;
         12'h3b0: csr = PMPADDR0;
         12'h3b1: csr = PMPADDR1;
         12'h3b2: csr = PMPADDR2;
         12'h3b3: csr = PMPADDR3;
         12'hc00: csr = RDCYCLE_CSR;
         12'hc01: csr = RDTIME_CSR;
         12'hc02: csr = RDINSTRET_CSR;
         12'hf14: csr = MHARTID;
         default: csr = BADCSR;
      endcase
   end

endmodule

/* rtl/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen #(
   parameter int XLEN = 64
) (
   input  logic [31:0]             insn,
   input  logic [XLEN-1:0]         pc,
   input  riscv_isa_pkg::imm_fmt_t fmt,
   uop_if.imm_drv                  u
);
   import riscv_isa_pkg::*;

   logic [XLEN-1:0] i_imm;
   logic [XLEN-1:0] s_imm;
   logic [XLEN-1:0] b_off;
   logic [XLEN-1:0] u_imm;
   logic [XLEN-1:0] j_off;
   logic            is_auipc;

   assign i_imm = XLEN'($signed(insn[31:20]));
   assign s_imm = XLEN'($signed({insn[31:25], insn[11:7]}));
   assign b_off = XLEN'($signed({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}));
   assign u_imm = XLEN'($signed({insn[31:12], 12'd0}));
   assign j_off = XLEN'($signed({insn[31], insn[19:12], insn[20], insn[30:21], 1'b0}));

   // lui and auipc share the U format
   assign is_auipc = (insn[6:0] == OPC_AUIPC);

   always_comb
   begin
      case (fmt)
         IMM_I:   u.imm = i_imm;
         IMM_S:   u.imm = s_imm;
         IMM_B:   u.imm = pc + b_off;      // branch target
         IMM_U:   u.imm = is_auipc ? pc + u_imm : u_imm;
         IMM_J:   u.imm = pc + j_off;      // jal target
         IMM_CSR: u.imm = XLEN'(insn[19:15]);
         default: u.imm = '0;
      endcase
   end

endmodule

/* rtl/uop_classify.sv */
`timescale 1ns/1ps

module uop_classify #(
   parameter int PREG_W = 6
) (
   input  logic [31:0]             insn,
   input  logic                    page_fault,
   output riscv_isa_pkg::imm_fmt_t fmt,
   uop_if.classify                 u
);
   import riscv_isa_pkg::*;
   import uop_pkg::*;

   logic [PREG_W-1:0] rd;
   logic [PREG_W-1:0] rs1;
   logic [PREG_W-1:0] rs2;
   logic [2:0]        f3;
   logic              rs1_link;
   logic              int_wr;
   csr_t              csr_id;

   assign rd       = PREG_W'(insn[11:7]);
   assign rs1      = PREG_W'(insn[19:15]);
   assign rs2      = PREG_W'(insn[24:20]);
   assign f3       = insn[14:12];
   assign rs1_link = (insn[19:15] == 5'd1) || (insn[19:15] == 5'd5);

   csr_map u_csr_map (
      .addr (insn[31:20]),
      .csr  (csr_id)
   );

   always_comb
   begin
      u.op = II;
      u.dst = rd;
      u.src_a = rs1;
      u.src_b = rs2;
      u.dst_valid = 1'b0;
      u.src_a_valid = 1'b0;
      u.src_b_valid = 1'b0;
      u.is_br = 1'b0;
      u.is_mem = 1'b0;
      u.is_store = 1'b0;
      u.serializing = 1'b0;
      u.csr = BADCSR;
      fmt = IMM_NONE;
      int_wr = 1'b0;               // rd = 0 turns these into nop
      case (opcode_t'(insn[6:0]))
         OPC_LOAD:
         begin
            u.dst_valid = 1'b1;
            u.src_a_valid = 1'b1;
            u.is_mem = 1'b1;
            fmt = IMM_I;
            case (f3)
               3'd0: u.op = LB;
               3'd1: u.op = LH;
               3'd2: u.op = LW;
               3'd3: u.op = LD;
               3'd4: u.op = LBU;
               3'd5: u.op = LHU;
               3'd6: u.op = LWU;
               default: u.op = II;
            endcase
         end
         OPC_MISC_MEM:
            u.op = NOP;            // fence, in-order pipe
         OPC_OP_IMM:
         begin
            u.dst_valid = 1'b1;
            u.src_a_valid = 1'b1;
            int_wr = 1'b1;
            fmt = IMM_I;
            case (f3)
               3'd0: u.op = ADDI;
               3'd1: u.op = (insn[31:26] == 6'h00) ? SLLI : II;
               3'd2: u.op = SLTI;
               3'd3: u.op = SLTIU;
               3'd4: u.op = XORI;
               3'd5: u.op = (insn[31:26] == 6'h00) ? SRLI : (insn[31:26] == 6'h10) ? SRAI : II;
               3'd6: u.op = ORI;
               default: u.op = ANDI;
            endcase
         end
         OPC_AUIPC, OPC_LUI:
         begin
            u.op = insn[5] ? LUI : AUIPC;
            u.dst_valid = 1'b1;
            int_wr = 1'b1;
            fmt = IMM_U;
         end
         OPC_STORE:
         begin
            u.src_a_valid = 1'b1;
            u.src_b_valid = 1'b1;
            u.is_mem = 1'b1;
            u.is_store = 1'b1;
            fmt = IMM_S;
            case (f3)
               3'd0: u.op = SB;
               3'd1: u.op = SH;
               3'd2: u.op = SW;
               3'd3: u.op = SD;
               default: u.op = II;
            endcase
         end
         OPC_OP:
         begin
            u.dst_valid = 1'b1;
            u.src_a_valid = 1'b1;
            u.src_b_valid = 1'b1;
            int_wr = 1'b1;
            case ({insn[31:25], f3})
               {7'h00, 3'd0}: u.op = ADDU;
               {7'h20, 3'd0}: u.op = SUBU;
               {7'h00, 3'd1}: u.op = SLL;
               {7'h00, 3'd2}: u.op = SLT;
               {7'h00, 3'd3}: u.op = SLTU;
               {7'h00, 3'd4}: u.op = XOR;
               {7'h00, 3'd5}: u.op = SRL;
               {7'h20, 3'd5}: u.op = SRA;
               {7'h00, 3'd6}: u.op = OR;
               {7'h00, 3'd7}: u.op = AND;
               default: u.op = II;         // includes the M extension
            endcase
         end
         OPC_BRANCH:
         begin
            u.src_a_valid = 1'b1;
            u.src_b_valid = 1'b1;
            u.is_br = 1'b1;
            fmt = IMM_B;
            case (f3)
               3'd0: u.op = BEQ;
               3'd1: u.op = BNE;
               3'd4: u.op = BLT;
               3'd5: u.op = BGE;
               3'd6: u.op = BLTU;
               3'd7: u.op = BGEU;
               default: u.op = II;
            endcase
         end
         OPC_JALR:
         begin
            u.dst_valid = 1'b1;
            u.src_a_valid = 1'b1;
            u.is_br = 1'b1;
            fmt = IMM_I;
            if (f3 != 3'd0)
               u.op = II;
            else if (insn[11:7] != 5'd0)
               u.op = JALR;
            else
               u.op = rs1_link ? RET : JR;
         end
         OPC_JAL:
         begin
            u.op = (insn[11:7] == 5'd0) ? J : JAL;
            u.dst_valid = 1'b1;
            u.is_br = 1'b1;
            fmt = IMM_J;
         end
         OPC_SYSTEM:
         begin
            u.serializing = 1'b1;
            if (insn[31:7] == 25'd0)
               u.op = ECALL;
            else if (insn[31:7] == {12'h001, 13'd0})
               u.op = EBREAK;
            else if (f3[1:0] != 2'd0 && csr_id != BADCSR)
            begin
               u.csr = csr_id;
               u.dst_valid = 1'b1;
               u.src_a_valid = ~f3[2];    // immediate forms read no register
               fmt = f3[2] ? IMM_CSR : IMM_NONE;
               case (f3[1:0])
                  2'd1: u.op = f3[2] ? CSRRWI : CSRRW;
                  2'd2: u.op = f3[2] ? CSRRSI : CSRRS;
                  default: u.op = f3[2] ? CSRRCI : CSRRC;
               endcase
            end
         end
         default: u.op = II;
      endcase

      u.dst_valid = u.dst_valid && (insn[11:7] != 5'd0);
      if (int_wr && insn[11:7] == 5'd0 && u.op != II)
         u.op = NOP;

      // nothing of a dropped instruction reaches the backend
      if (page_fault || u.op == II || u.op == NOP)
      begin
         u.dst = '0;
         u.src_a = '0;
         u.src_b = '0;
         u.dst_valid = 1'b0;
         u.src_a_valid = 1'b0;
         u.src_b_valid = 1'b0;
         u.is_br = 1'b0;
         u.is_mem = 1'b0;
         u.is_store = 1'b0;
         u.serializing = 1'b0;
         u.csr = BADCSR;
         fmt = IMM_NONE;
      end
      if (page_fault)
         u.op = FETCH_PF;
   end

endmodule

/* rtl/uop_reg.sv */
`timescale 1ns/1ps

module uop_reg #(
   parameter int XLEN   = 64,
   parameter int PREG_W = 6
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   output logic                in_ready,
   input  logic [XLEN-1:0]     pc,
   uop_if.sink                 u,
   output logic                out_valid,
   input  logic                out_ready,
   output logic [XLEN-1:0]     out_pc,
   output uop_pkg::op_t        out_op,
   output logic [PREG_W-1:0]   out_dst,
   output logic                out_dst_valid,
   output logic [PREG_W-1:0]   out_src_a,
   output logic                out_src_a_valid,
   output logic [PREG_W-1:0]   out_src_b,
   output logic                out_src_b_valid,
   output logic [XLEN-1:0]     out_imm,
   output logic                out_is_br,
   output logic                out_is_mem,
   output logic                out_is_store,
   output logic                out_serializing,
   output riscv_isa_pkg::csr_t out_csr
);

   // slot is free when empty or being drained this cycle
   assign in_ready = ~out_valid | out_ready;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         out_valid <= 1'b0;
      else if (in_ready)
         out_valid <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
      begin
         out_pc          <= pc;
         out_op          <= u.op;
         out_dst         <= u.dst;
         out_dst_valid   <= u.dst_valid;
         out_src_a       <= u.src_a;
         out_src_a_valid <= u.src_a_valid;
         out_src_b       <= u.src_b;
         out_src_b_valid <= u.src_b_valid;
         out_imm         <= u.imm;
         out_is_br       <= u.is_br;
         out_is_mem      <= u.is_mem;
         out_is_store    <= u.is_store;
         out_serializing <= u.serializing;
         out_csr         <= u.csr;
      end
   end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage #(
   parameter int XLEN   = 64,
   parameter int PREG_W = 6
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                in_valid,
   output logic                in_ready,
   input  logic [31:0]         insn,
   input  logic [XLEN-1:0]     pc,
   input  logic                page_fault,
   output logic                out_valid,
   input  logic                out_ready,
   output logic [XLEN-1:0]     out_pc,
   output uop_pkg::op_t        out_op,
   output logic [PREG_W-1:0]   out_dst,
   output logic                out_dst_valid,
   output logic [PREG_W-1:0]   out_src_a,
   output logic                out_src_a_valid,
   output logic [PREG_W-1:0]   out_src_b,
   output logic                out_src_b_valid,
   output logic [XLEN-1:0]     out_imm,
   output logic                out_is_br,
   output logic                out_is_mem,
   output logic                out_is_store,
   output logic                out_serializing,
   output riscv_isa_pkg::csr_t out_csr
);
   import riscv_isa_pkg::*;

   imm_fmt_t imm_fmt;

   uop_if #(.XLEN(XLEN), .PREG_W(PREG_W)) uop_bus ();

   uop_classify #(.PREG_W(PREG_W)) u_classify (
      .insn       (insn),
      .page_fault (page_fault),
      .fmt        (imm_fmt),
      .u          (uop_bus.classify)
   );

   imm_gen #(.XLEN(XLEN)) u_imm_gen (
      .insn (insn),
      .pc   (pc),
      .fmt  (imm_fmt),
      .u    (uop_bus.imm_drv)
   );

   uop_reg #(.XLEN(XLEN), .PREG_W(PREG_W)) u_uop_reg (
      .clk             (clk),
      .rst_n           (rst_n),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .pc              (pc),
      .u               (uop_bus.sink),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .out_pc          (out_pc),
      .out_op          (out_op),
      .out_dst         (out_dst),
      .out_dst_valid   (out_dst_valid),
      .out_src_a       (out_src_a),
      .out_src_a_valid (out_src_a_valid),
      .out_src_b       (out_src_b),
      .out_src_b_valid (out_src_b_valid),
      .out_imm         (out_imm),
      .out_is_br       (out_is_br),
      .out_is_mem      (out_is_mem),
      .out_is_store    (out_is_store),
      .out_serializing (out_serializing),
      .out_csr         (out_csr)
   );

endmodule

/* dv/decode_sva.sv */
`timescale 1ns/1ps

module decode_sva #(
   parameter int XLEN   = 64,
   parameter int PREG_W = 6
) (
   input logic                clk,
   input logic                rst_n,
   input logic                in_ready,
   input logic                out_valid,
   input logic                out_ready,
   input logic [XLEN-1:0]     out_pc,
   input uop_pkg::op_t        out_op,
   input logic [PREG_W-1:0]   out_dst,
   input logic                out_dst_valid,
   input logic [PREG_W-1:0]   out_src_a,
   input logic                out_src_a_valid,
   input logic [PREG_W-1:0]   out_src_b,
   input logic                out_src_b_valid,
   input logic [XLEN-1:0]     out_imm,
   input logic                out_is_br,
   input logic                out_is_mem,
   input logic                out_is_store,
   input logic                out_serializing,
   input riscv_isa_pkg::csr_t out_csr
);

   logic [2*XLEN+3*PREG_W+17:0] fields;

   assign fields = {out_pc, out_op, out_dst, out_dst_valid, out_src_a, out_src_a_valid,
                    out_src_b, out_src_b_valid, out_imm, out_is_br, out_is_mem,
                    out_is_store, out_serializing, out_csr};

   a_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
      else $error("out_valid high right after reset");

   // stalled output must hold
   a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(fields))
      else $error("output changed or dropped under back-pressure");

   a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
      in_ready == (out_ready || !out_valid))
      else $error("in_ready does not follow out_ready and out_valid");

endmodule

bind uop_reg decode_sva #(.XLEN(XLEN), .PREG_W(PREG_W)) u_decode_sva (.*);

/* dv/tb_decode.sv */
`timescale 1ns/1ps

module tb_decode;
   import riscv_isa_pkg::*;
   import uop_pkg::*;

   localparam int XLEN       = 64;
   localparam int PREG_W     = 6;
   localparam int MAX_CYCLES = 2000;   // about 5x the ~350 cycles all tests need

   typedef struct packed {
      op_t               op;
      logic [PREG_W-1:0] dst;
      logic              dst_valid;
      logic [PREG_W-1:0] src_a;
      logic              src_a_valid;
      logic [PREG_W-1:0] src_b;
      logic              src_b_valid;
      logic [XLEN-1:0]   imm;
      logic              is_br;
      logic              is_mem;
      logic              is_store;
      logic              serializing;
      csr_t              csr;
   } uop_t;

   logic              clk;
   logic              rst_n;
   logic              in_valid;
   logic              in_ready;
   logic [31:0]       insn;
   logic [XLEN-1:0]   pc;
   logic              page_fault;
   logic              out_valid;
   logic              out_ready;
   logic [XLEN-1:0]   out_pc;
   op_t               out_op;
   logic [PREG_W-1:0] out_dst;
   logic              out_dst_valid;
   logic [PREG_W-1:0] out_src_a;
   logic              out_src_a_valid;
   logic [PREG_W-1:0] out_src_b;
   logic              out_src_b_valid;
   logic [XLEN-1:0]   out_imm;
   logic              out_is_br;
   logic              out_is_mem;
   logic              out_is_store;
   logic              out_serializing;
   csr_t              out_csr;

   int              cyc = 0;
   bit              seen = 1'b0;     // head output already checked for latency
   bit              bp_on = 1'b0;
   string           test_name = "reset";
   uop_t            exp_q [$];
   logic [XLEN-1:0] pc_q [$];
   int              acc_q [$];         // cycle of the accept edge

   // op by funct3
   op_t ld_ops [0:7]  = '{LB, LH, LW, LD, LBU, LHU, LWU, II};
   op_t st_ops [0:7]  = '{SB, SH, SW, SD, II, II, II, II};
   op_t imm_ops [0:7] = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI};
   op_t rr_ops [0:7]  = '{ADDU, SLL, SLT, SLTU, XOR, SRL, OR, AND};
   op_t br_ops [0:7]  = '{BEQ, BNE, II, II, BLT, BGE, BLTU, BGEU};
   op_t csr_ops [0:7] = '{II, CSRRW, CSRRS, CSRRC, II, CSRRWI, CSRRSI, CSRRCI};
   logic [6:0] rnd_opcs [0:9] = '{OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_STORE, OPC_OP,
                                  OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL, OPC_MISC_MEM};
   logic [11:0] csr_addrs [0:11] = '{12'h100, 12'h105, 12'h180, 12'h300, 12'h341, 12'h3a0,
                                     12'h3b3, 12'hc00, 12'hf14, 12'h7c0, 12'hb00, 12'h3a1};

   decode_stage #(.XLEN(XLEN), .PREG_W(PREG_W)) DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      forever
      begin
         @(posedge clk);
         cyc++;
         if (cyc >= MAX_CYCLES)
         begin
            $display("timeout after %0d cycles in %s", cyc, test_name);
            stop_on_error();
         end
      end
   end

   initial
   begin
      out_ready = 1'b0;
      forever
      begin
         @(posedge clk);
         #1;
         out_ready = bp_on ? 1'($urandom % 2) : 1'b1;
      end
   end

   initial
   begin
      forever
      begin
         @(negedge clk);              // outputs are settled here
         if (rst_n && out_valid)
            check_output();
      end
   end

   task automatic stop_on_error();
      $display("ERRORS FOUND");
      $fatal(1, "run stopped at first error");
   endtask

   function automatic csr_t csr_expect(input logic [11:0] a);
      case (a)
         12'h100: return SSTATUS;
         12'h105: return STVEC;
         12'h180: return SATP;
         12'h300: return MSTATUS;
         12'h341: return MEPC;
         12'h3a0: return PMPCFG0;
         12'h3b3: return PMPADDR3;
         12'hc00: return RDCYCLE_CSR;
         12'hf14: return MHARTID;
         default: return BADCSR;
      endcase
   endfunction

   function automatic uop_t ref_decode(input logic [31:0] w, input logic [XLEN-1:0] p,
                                       input logic f);
      uop_t            e;
      op_t             keep;
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [2:0]      f3;
      logic [6:0]      f7;
      logic [XLEN-1:0] imm_i;
      logic [XLEN-1:0] imm_s;
      logic [XLEN-1:0] imm_b;
      logic [XLEN-1:0] imm_u;
      logic [XLEN-1:0] imm_j;
      logic            int_wr;
      rd = w[11:7];
      rs1 = w[19:15];
      f3 = w[14:12];
      f7 = w[31:25];
      imm_i = {{52{w[31]}}, w[31:20]};
      imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_u = {{32{w[31]}}, w[31:12], 12'h000};
      imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      e = '0;
      e.op = II;
      e.csr = BADCSR;
      e.dst = {1'b0, rd};
      e.src_a = {1'b0, rs1};
      e.src_b = {1'b0, w[24:20]};
      int_wr = 1'b0;
      case (w[6:0])
         OPC_LOAD:
         begin
            e.op = ld_ops[f3];
            e.dst_valid = 1'b1;
            e.src_a_valid = 1'b1;
            e.is_mem = 1'b1;
            e.imm = imm_i;
         end
         OPC_STORE:
         begin
            e.op = st_ops[f3];
            e.src_a_valid = 1'b1;
            e.src_b_valid = 1'b1;
            e.is_mem = 1'b1;
            e.is_store = 1'b1;
            e.imm = imm_s;
         end
         OPC_OP_IMM:
         begin
            e.op = imm_ops[f3];
            if (f3 == 3'd1 && w[31:26] != 6'h00)
               e.op = II;
            if (f3 == 3'd5)
               e.op = (w[31:26] == 6'h00) ? SRLI : (w[31:26] == 6'h10) ? SRAI : II;
            e.dst_valid = 1'b1;
            e.src_a_valid = 1'b1;
            e.imm = imm_i;
            int_wr = 1'b1;
         end
         OPC_OP:
         begin
            e.op = (f7 == 7'h00) ? rr_ops[f3] : II;
            if (f7 == 7'h20 && f3 == 3'd0)
               e.op = SUBU;
            if (f7 == 7'h20 && f3 == 3'd5)
               e.op = SRA;
            e.dst_valid = 1'b1;
            e.src_a_valid = 1'b1;
            e.src_b_valid = 1'b1;
            int_wr = 1'b1;
         end
         OPC_LUI, OPC_AUIPC:
         begin
            e.op = (w[6:0] == OPC_LUI) ? LUI : AUIPC;
            e.imm = (w[6:0] == OPC_LUI) ? imm_u : p + imm_u;
            e.dst_valid = 1'b1;
            int_wr = 1'b1;
         end
         OPC_BRANCH:
         begin
            e.op = br_ops[f3];
            e.src_a_valid = 1'b1;
            e.src_b_valid = 1'b1;
            e.is_br = 1'b1;
            e.imm = p + imm_b;
         end
         OPC_JALR:
         begin
            e.op = (f3 != 3'd0) ? II : (rd != 5'd0) ? JALR :
                   (rs1 == 5'd1 || rs1 == 5'd5) ? RET : JR;
            e.dst_valid = 1'b1;
            e.src_a_valid = 1'b1;
            e.is_br = 1'b1;
            e.imm = imm_i;
         end
         OPC_JAL:
         begin
            e.op = (rd == 5'd0) ? J : JAL;
            e.dst_valid = 1'b1;
            e.is_br = 1'b1;
            e.imm = p + imm_j;
         end
         OPC_MISC_MEM:
            e.op = NOP;
         OPC_SYSTEM:
         begin
            e.serializing = 1'b1;
            if (w[31:7] == 25'h0)
               e.op = ECALL;
            else if (w[31:7] == 25'h2000)
               e.op = EBREAK;
            else if (csr_ops[f3] != II && csr_expect(w[31:20]) != BADCSR)
            begin
               e.op = csr_ops[f3];
               e.csr = csr_expect(w[31:20]);
               e.dst_valid = 1'b1;
               e.src_a_valid = !f3[2];
               e.imm = f3[2] ? {59'd0, rs1} : '0;   // uimm forms
            end
         end
         default:
            e.op = II;
      endcase
      e.dst_valid = e.dst_valid && rd != 5'd0;
      if (int_wr && rd == 5'd0 && e.op != II)
         e.op = NOP;
      if (f || e.op == II || e.op == NOP)
      begin
         keep = e.op;
         e = '0;
         e.op = f ? FETCH_PF : keep;
         e.csr = BADCSR;
      end
      return e;
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
   endfunction

   function automatic logic [4:0] rnd5();
      return 5'($urandom);
   endfunction

   function automatic logic [XLEN-1:0] rnd_pc();
      return {$urandom, $urandom} & ~64'h3;
   endfunction

   // called 1 ns after a rising edge, returns 1 ns after the accept edge
   task automatic send(input logic [31:0] w, input logic [XLEN-1:0] p, input logic f);
      in_valid = 1'b1;
      insn = w;
      pc = p;
      page_fault = f;
      @(negedge clk);
      while (!in_ready)
         @(negedge clk);
      exp_q.push_back(ref_decode(w, p, f));
      pc_q.push_back(p);
      acc_q.push_back(cyc + 1);
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != 0)
         @(negedge clk);
      @(posedge clk);
      #1;
      assert (!out_valid)
      else
      begin
         $display("%s: out_valid still high after every output was taken", test_name);
         stop_on_error();
      end
   endtask

   task automatic check_output();
      uop_t act;
      act.op = out_op;
      act.dst = out_dst;
      act.dst_valid = out_dst_valid;
      act.src_a = out_src_a;
      act.src_a_valid = out_src_a_valid;
      act.src_b = out_src_b;
      act.src_b_valid = out_src_b_valid;
      act.imm = out_imm;
      act.is_br = out_is_br;
      act.is_mem = out_is_mem;
      act.is_store = out_is_store;
      act.serializing = out_serializing;
      act.csr = out_csr;
      assert (exp_q.size() > 0)
      else
      begin
         $display("%s: out_valid high with no instruction outstanding", test_name);
         stop_on_error();
      end
      if (!seen)
      begin
         assert (cyc == acc_q[0])
         else
         begin
            $display("error %s latency: expected cycle %0d, actual cycle %0d",
                     test_name, acc_q[0], cyc);
            stop_on_error();
         end
         seen = 1'b1;
      end
      assert (act == exp_q[0] && out_pc == pc_q[0])
      else
      begin
         $display("error %s: expected %s imm %h pc %h uop %h, actual %s imm %h pc %h uop %h",
                  test_name, exp_q[0].op.name(), exp_q[0].imm, pc_q[0], exp_q[0],
                  act.op.name(), act.imm, out_pc, act);
         stop_on_error();
      end
      if (out_ready)                 // taken at the next edge
      begin
         void'(exp_q.pop_front());
         void'(pc_q.pop_front());
         void'(acc_q.pop_front());
         seen = 1'b0;
      end
   endtask

   task automatic test_int_ops();
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [11:0] imm;
      test_name = "int_ops";
      for (int i = 0; i < 24; i++)
      begin
         rd = (i % 4 == 0) ? 5'd0 : rnd5();
         f3 = 3'(i);
         f7 = (i % 3 == 0) ? 7'h00 : (i % 3 == 1) ? 7'h20 : 7'h01;   // 7'h01 is M ext
         imm = 12'($urandom);
         if (i % 3 == 0 && (f3 == 3'd1 || f3 == 3'd5))
            imm[11:6] = 6'h00;
         else if (i % 3 == 1 && f3 == 3'd5)
            imm[11:6] = 6'h10;
         send(enc_i(imm, rnd5(), f3, rd, OPC_OP_IMM), rnd_pc(), 1'b0);
         send(enc_r(f7, rnd5(), rnd5(), f3, rd, OPC_OP), rnd_pc(), 1'b0);
      end
      drain();
   endtask

   task automatic test_upper_branch_jump();
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [12:0] boff;
      logic [20:0] joff;
      test_name = "upper_branch_jump";
      for (int i = 0; i < 8; i++)
      begin
         rd = (i % 4 == 0) ? 5'd0 : rnd5();
         rs1 = (i % 3 == 0) ? 5'd1 : (i % 3 == 1) ? 5'd5 : rnd5();
         boff = {1'(i % 2), 11'($urandom), 1'b0};   // odd i goes backwards
         joff = {1'(i % 2), 19'($urandom), 1'b0};
         send({20'($urandom), rd, 7'h37}, rnd_pc(), 1'b0);
         send({20'($urandom), rnd5(), 7'h17}, rnd_pc(), 1'b0);
         send(enc_b(boff, rnd5(), rnd5(), 3'(i)), rnd_pc(), 1'b0);
         send(enc_j(joff, rd), rnd_pc(), 1'b0);
         send(enc_i(12'($urandom), rs1, 3'd0, (i < 4) ? 5'd0 : rd, OPC_JALR), rnd_pc(), 1'b0);
      end
      drain();
   endtask

   task automatic test_load_store();
      test_name = "load_store";
      for (int i = 0; i < 8; i++)
      begin
         send(enc_i(12'($urandom), rnd5(), 3'(i), (i == 0) ? 5'd0 : rnd5(), OPC_LOAD),
              rnd_pc(), 1'b0);
         send(enc_s(12'($urandom), rnd5(), rnd5(), 3'(i)), rnd_pc(), 1'b0);
      end
      drain();
   endtask

   task automatic test_csr_system();
      test_name = "csr_system";
      for (int k = 0; k < 12; k++)
      begin
         for (int f = 0; f < 8; f++)
            send(enc_i(csr_addrs[k], rnd5(), 3'(f), rnd5(), OPC_SYSTEM), rnd_pc(), 1'b0);
      end
      send(32'h0000_0073, rnd_pc(), 1'b0);   // ecall
      send(32'h0010_0073, rnd_pc(), 1'b0);   // ebreak
      drain();
   endtask

   task automatic test_page_fault();
      test_name = "page_fault";
      for (int i = 0; i < 8; i++)
      begin
         send($urandom, rnd_pc(), 1'b1);
         send(enc_r(7'h00, rnd5(), rnd5(), 3'(i), rnd5(), OPC_OP), rnd_pc(), 1'b1);
      end
      send(32'h0000_0073, rnd_pc(), 1'b1);
      drain();
   endtask

   task automatic test_back_pressure();
      test_name = "back_pressure";
      bp_on = 1'b1;
      for (int i = 0; i < 40; i++)
         send({25'($urandom), rnd_opcs[4'($urandom % 10)]}, rnd_pc(), ($urandom % 8) == 0);
      drain();
      bp_on = 1'b0;
   endtask

   initial
   begin
      void'($urandom(32'h13de454b));
      rst_n = 1'b0;
      in_valid = 1'b0;
      insn = '0;
      pc = '0;
      page_fault = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      test_int_ops();
      test_upper_branch_jump();
      test_load_store();
      test_csr_system();
      test_page_fault();
      test_back_pressure();
      $display("NO ERRORS");
      $finish;
   end

endmodule

/* project.f */
rtl/riscv_isa_pkg.sv
rtl/uop_pkg.sv
rtl/uop_if.sv
rtl/csr_map.sv
rtl/imm_gen.sv
rtl/uop_classify.sv
rtl/uop_reg.sv
rtl/decode_stage.sv
dv/decode_sva.sv
dv/tb_decode.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_decode
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
